//--- logic/cache_pkg.sv
package cache_pkg;

  // --------------------------------------------------
  // widths
  // --------------------------------------------------
  // line index, also used as the refill id
  localparam int LINE_IDX_W = 6;
  // set/way/offset field, bit 0 picks the offset
  localparam int SWO_W      = 7;

  // request opcode bit positions
  localparam int REQ_OP_WRITE_BIT = 0;
  localparam int REQ_OP_EVICT_BIT = 1;

  // state of one cache-line offset
  typedef logic [1:0] line_state_t;

  // --------------------------------------------------
  // request from the tag pipeline
  // --------------------------------------------------
  typedef struct packed {
    logic             cacheline_inflight;
    logic             need_linefill;
    logic [2:0]       rob_id;
    logic [1:0]       ch_id;
    logic [1:0]       opcode;
    logic [SWO_W-1:0] set_way_offset;
    logic [7:0]       wbuffer_id;
    line_state_t      state0;
    line_state_t      state1;
  } isu_req_t;

  // sram controller command
  typedef enum logic [2:0] {
    WRITE         = 3'd0,
    READ          = 3'd1,
    READ_LINEFILL = 3'd2,
    WRITE_BACK    = 3'd3
  } sc_opcode_e;

  // line index of a request, matched against refill ids
  function automatic logic [LINE_IDX_W-1:0] req_line_idx(input isu_req_t req);
    return req.set_way_offset[SWO_W-1:1];
  endfunction

endpackage

//--- logic/bus_pkg.sv
package bus_pkg;

  import cache_pkg::*;

  // --------------------------------------------------
  // refill data from the bus interface
  // --------------------------------------------------
  localparam int LINE_BITS = 256;
  localparam int HALF_BITS = LINE_BITS / 2;

  // one full line per beat, no back-pressure
  typedef struct packed {
    logic                  valid;
    logic [LINE_IDX_W-1:0] rid;
    logic [LINE_BITS-1:0]  data;
  } biu_refill_t;

  // --------------------------------------------------
  // issue bundle towards the sram controller
  // --------------------------------------------------
  typedef struct packed {
    logic [1:0]           channel_id;
    sc_opcode_e           opcode;
    logic [SWO_W-1:0]     set_way_offset;
    logic [7:0]           wbuffer_id;
    logic [2:0]           rob_num;
    line_state_t          state0;
    line_state_t          state1;
    // low half of the line
    logic [HALF_BITS-1:0] data0;
    // high half of the line
    logic [HALF_BITS-1:0] data1;
  } sc_issue_t;

endpackage

//--- logic/shift_priority_arb.sv
`timescale 1ns/1ps

module shift_priority_arb #(
  parameter int PTR_WIDTH = 3
) (
  input  logic [(1<<PTR_WIDTH)-1:0] eligible_i,
  input  logic [PTR_WIDTH-1:0]      bottom_ptr_i,
  output logic [PTR_WIDTH-1:0]      select_ptr_o,
  output logic                      select_any_o
);

  localparam int DEPTH = 1 << PTR_WIDTH;

  logic [2*DEPTH-1:0]   eligible_dbl;
  logic [DEPTH-1:0]     eligible_rot;
  logic [PTR_WIDTH-1:0] first_offset;

  // --------------------------------------------------
  // rotate so that the bottom slot sits at bit 0
  // --------------------------------------------------
  assign eligible_dbl = {eligible_i, eligible_i};
  assign eligible_rot = eligible_dbl[bottom_ptr_i +: DEPTH];

  // --------------------------------------------------
  // lowest set bit, then back to a slot index
  // --------------------------------------------------
  always_comb begin
    first_offset = '0;
    // scan downward so the lowest set bit wins
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (eligible_rot[i]) begin
        first_offset = PTR_WIDTH'(i);
      end
    end

    select_any_o = |eligible_i;
    // wraps modulo the depth through the pointer width
    select_ptr_o = bottom_ptr_i + first_offset;

    // rotate and add back must agree on the same slot
    if (select_any_o) begin
      assert (eligible_i[select_ptr_o])
        else $error("arb: slot %0d selected but not eligible (vec %h, bottom %0d)",
                    select_ptr_o, eligible_i, bottom_ptr_i);
    end
  end

endmodule

//--- logic/linefill_buffer.sv
`timescale 1ns/1ps

module linefill_buffer
  import cache_pkg::*, bus_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  biu_refill_t           refill_i,
  input  logic [LINE_IDX_W-1:0] raddr_i,
  output logic [LINE_BITS-1:0]  rdata_o
);

  localparam int LINES = 1 << LINE_IDX_W;

  logic [LINE_BITS-1:0] line_mem [LINES];
  // lines written at least once since reset
  logic [LINES-1:0]     line_vld_q;

  // --------------------------------------------------
  // line storage
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (refill_i.valid) begin
      line_mem[refill_i.rid] <= refill_i.data;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      line_vld_q <= '0;
    end else if (refill_i.valid) begin
      line_vld_q[refill_i.rid] <= 1'b1;
    end
  end

  // --------------------------------------------------
  // asynchronous read
  // --------------------------------------------------
  // never-filled lines read as zero
  assign rdata_o = line_vld_q[raddr_i] ? line_mem[raddr_i] : '0;

  // an unknown id would corrupt an arbitrary line
  a_rid_known: assert property (
    @(posedge clk_i) disable iff (rst_i)
    refill_i.valid |-> !$isunknown(refill_i.rid)
  ) else $error("lfb: refill beat with unknown rid %h", refill_i.rid);

endmodule

//--- logic/bank_isu_iq.sv
`timescale 1ns/1ps

module bank_isu_iq
  import cache_pkg::*, bus_pkg::*;
#(
  parameter int PTR_WIDTH = 3
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      req_valid_i,
  input  isu_req_t                  req_i,
  output logic                      req_allow_in_o,
  input  biu_refill_t               refill_i,
  output logic [(1<<PTR_WIDTH)-1:0] eligible_o,
  output logic [PTR_WIDTH-1:0]      bottom_ptr_o,
  input  logic [PTR_WIDTH-1:0]      select_ptr_i,
  input  logic                      select_any_i,
  output logic [LINE_IDX_W-1:0]     lfb_raddr_o,
  input  logic [LINE_BITS-1:0]      lfb_rdata_i,
  output logic                      sc_valid_o,
  input  logic                      sc_ready_i,
  output sc_issue_t                 sc_o
);

  localparam int DEPTH = 1 << PTR_WIDTH;

  isu_req_t             slot_req_q [DEPTH];
  logic [DEPTH-1:0]     slot_vld_q;
  logic [DEPTH-1:0]     slot_vld_d;
  logic [DEPTH-1:0]     mshr_allow_q;
  logic [DEPTH-1:0]     mshr_allow_d;
  logic [DEPTH-1:0]     refill_match;
  logic [PTR_WIDTH-1:0] wr_ptr_q;
  logic [PTR_WIDTH-1:0] bottom_ptr_q;
  logic                 enq;
  logic                 deq;
  isu_req_t             sel_req;
  logic                 sel_write;
  logic                 sel_evict;
  logic                 sel_linefill;
  sc_opcode_e           sel_opcode;

  // --------------------------------------------------
  // enqueue
  // --------------------------------------------------
  // allow-in uses registered state only
  assign req_allow_in_o = ~slot_vld_q[wr_ptr_q];
  assign enq            = req_valid_i & req_allow_in_o;
  assign deq            = sc_valid_o & sc_ready_i;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
    end else if (enq) begin
      wr_ptr_q <= wr_ptr_q + 1'b1;
    end
  end

  // request payload
  always_ff @(posedge clk_i) begin
    if (enq) begin
      slot_req_q[wr_ptr_q] <= req_i;
    end
  end

  // --------------------------------------------------
  // valid array
  // --------------------------------------------------
  always_comb begin
    slot_vld_d = slot_vld_q;
    if (deq) begin
      slot_vld_d[select_ptr_i] = 1'b0;
    end
    // enq only targets a free slot and never the issued one
    if (enq) begin
      slot_vld_d[wr_ptr_q] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      slot_vld_q <= '0;
    end else begin
      slot_vld_q <= slot_vld_d;
    end
  end

  // --------------------------------------------------
  // mshr allow array
  // --------------------------------------------------
  // refill releases every live slot waiting on that line
  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      refill_match[i] = slot_vld_q[i] & refill_i.valid &
                        (req_line_idx(slot_req_q[i]) == refill_i.rid);
    end
  end

  always_comb begin
    mshr_allow_d = mshr_allow_q | refill_match;
    if (deq) begin
      mshr_allow_d[select_ptr_i] = 1'b0;
    end
    // a new slot ignores a refill on the same edge
    if (enq) begin
      mshr_allow_d[wr_ptr_q] = ~(req_i.need_linefill | req_i.cacheline_inflight);
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      mshr_allow_q <= '0;
    end else begin
      mshr_allow_q <= mshr_allow_d;
    end
  end

  // --------------------------------------------------
  // bottom pointer
  // --------------------------------------------------
  // walks over empty slots until it sits on the oldest entry
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      bottom_ptr_q <= '0;
    end else if (!slot_vld_q[bottom_ptr_q] && |slot_vld_q) begin
      bottom_ptr_q <= bottom_ptr_q + 1'b1;
    end
  end

  assign eligible_o   = slot_vld_q & mshr_allow_q;
  assign bottom_ptr_o = bottom_ptr_q;

  // --------------------------------------------------
  // issue
  // --------------------------------------------------
  assign sc_valid_o   = select_any_i;
  assign sel_req      = slot_req_q[select_ptr_i];
  assign sel_write    = sel_req.opcode[REQ_OP_WRITE_BIT];
  assign sel_evict    = sel_req.opcode[REQ_OP_EVICT_BIT];
  assign sel_linefill = sel_req.need_linefill;
  assign lfb_raddr_o  = req_line_idx(sel_req);

  // eviction first, then linefill, then write
  always_comb begin
    if (sel_evict) begin
      sel_opcode = WRITE_BACK;
    end else if (sel_linefill) begin
      sel_opcode = READ_LINEFILL;
    end else if (sel_write) begin
      sel_opcode = WRITE;
    end else begin
      sel_opcode = READ;
    end
  end

  always_comb begin
    sc_o.channel_id     = sel_req.ch_id;
    sc_o.opcode         = sel_opcode;
    sc_o.set_way_offset = sel_req.set_way_offset;
    sc_o.wbuffer_id     = sel_req.wbuffer_id;
    sc_o.rob_num        = sel_req.rob_id;
    sc_o.state0         = sel_req.state0;
    sc_o.state1         = sel_req.state1;
    sc_o.data0          = lfb_rdata_i[HALF_BITS-1:0];
    sc_o.data1          = lfb_rdata_i[LINE_BITS-1:HALF_BITS];
  end

  // --------------------------------------------------
  // assertions
  // --------------------------------------------------
  // the issued slot is live so it never collides with the enqueue slot
  a_enq_free: assert property (
    @(posedge clk_i) disable iff (rst_i)
    enq |-> !(deq && (select_ptr_i == wr_ptr_q))
  ) else $error("iq: enqueue into slot %0d while it issues", wr_ptr_q);

  // a pending issue is not withdrawn under back-pressure
  a_valid_hold: assert property (
    @(posedge clk_i) disable iff (rst_i)
    sc_valid_o && !sc_ready_i |=> sc_valid_o
  ) else $error("iq: issue valid dropped while ready was low");

  // arbiter pick must agree with queue state
  a_sel_elig: assert property (
    @(posedge clk_i) disable iff (rst_i)
    select_any_i |-> eligible_o[select_ptr_i]
  ) else $error("iq: selected slot %0d is not eligible", select_ptr_i);

endmodule

//--- logic/bank_isu_top.sv
`timescale 1ns/1ps

module bank_isu_top
  import cache_pkg::*, bus_pkg::*;
#(
  parameter int PTR_WIDTH = 3
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        req_valid_i,
  input  isu_req_t    req_i,
  output logic        req_allow_in_o,
  input  biu_refill_t refill_i,
  output logic        sc_valid_o,
  input  logic        sc_ready_i,
  output sc_issue_t   sc_o
);

  localparam int DEPTH = 1 << PTR_WIDTH;

  logic [DEPTH-1:0]      eligible;
  logic [PTR_WIDTH-1:0]  bottom_ptr;
  logic [PTR_WIDTH-1:0]  select_ptr;
  logic                  select_any;
  logic [LINE_IDX_W-1:0] lfb_raddr;
  logic [LINE_BITS-1:0]  lfb_rdata;

  // --------------------------------------------------
  // issue queue
  // --------------------------------------------------
  bank_isu_iq #(
    .PTR_WIDTH (PTR_WIDTH)
  ) u_iq (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .req_valid_i    (req_valid_i),
    .req_i          (req_i),
    .req_allow_in_o (req_allow_in_o),
    .refill_i       (refill_i),
    .eligible_o     (eligible),
    .bottom_ptr_o   (bottom_ptr),
    .select_ptr_i   (select_ptr),
    .select_any_i   (select_any),
    .lfb_raddr_o    (lfb_raddr),
    .lfb_rdata_i    (lfb_rdata),
    .sc_valid_o     (sc_valid_o),
    .sc_ready_i     (sc_ready_i),
    .sc_o           (sc_o)
  );

  // oldest-first pick from the bottom pointer
  shift_priority_arb #(
    .PTR_WIDTH (PTR_WIDTH)
  ) u_arb (
    .eligible_i   (eligible),
    .bottom_ptr_i (bottom_ptr),
    .select_ptr_o (select_ptr),
    .select_any_o (select_any)
  );

  linefill_buffer u_lfb (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .refill_i (refill_i),
    .raddr_i  (lfb_raddr),
    .rdata_o  (lfb_rdata)
  );

endmodule

//--- verif/bank_isu_tb_lib.svh
`ifndef BANK_ISU_TB_LIB_SVH
`define BANK_ISU_TB_LIB_SVH

// --------------------------------------------------
// test constants
// --------------------------------------------------
localparam int          WAIT_LIMIT  = 200;
localparam int          HOLD_CYCLES = 6;
localparam int          MAX_ROWS    = 24;
localparam logic [31:0] LFSR_SEED   = 32'd74;
// x^32 + x^22 + x^2 + x + 1, right-shifting form
localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;

// one request of the stimulus table and its issue position
typedef struct {
  int       test_id;
  isu_req_t req;
  bit       refill;
  int       order;
} req_row_t;

logic [31:0] lfsr_state;
int          check_count;
int          error_count;
int          test_errors;

function automatic logic [31:0] lfsr_next(input logic [31:0] state);
  logic [31:0] nxt;
  nxt = state >> 1;
  if (state[0]) begin
    nxt = nxt ^ LFSR_TAPS;
  end
  return nxt;
endfunction

// one lfsr step per data bit
task automatic make_line(output logic [LINE_BITS-1:0] line);
  for (int i = 0; i < LINE_BITS; i++) begin
    line[i]    = lfsr_state[0];
    lfsr_state = lfsr_next(lfsr_state);
  end
endtask

task automatic report_failure(input string msg);
  $display("%s", msg);
  error_count++;
  test_errors++;
endtask

task automatic check_value(input string name, input logic [HALF_BITS-1:0] exp,
                           input logic [HALF_BITS-1:0] got);
  check_count++;
  assert (got === exp)
    else report_failure($sformatf("error %s: expected %0h, got %0h", name, exp, got));
endtask

`endif

//--- verif/bank_isu_tb.sv
`timescale 1ns/1ps

module bank_isu_tb
  import cache_pkg::*, bus_pkg::*;
();

  logic        clk_i;
  logic        rst_i;
  logic        req_valid_i;
  isu_req_t    req_i;
  logic        req_allow_in_o;
  biu_refill_t refill_i;
  logic        sc_valid_o;
  logic        sc_ready_i;
  sc_issue_t   sc_o;

  `include "bank_isu_tb_lib.svh"

  req_row_t             rows [MAX_ROWS];
  int                   row_count;
  int                   ninth_row;
  int                   test_count;
  bit                   timed_out;
  sc_issue_t            issued_q [$];
  logic [LINE_BITS-1:0] line_model [64];
  logic [63:0]          line_known;

  bank_isu_top #(
    .PTR_WIDTH (3)
  ) dut_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .req_valid_i    (req_valid_i),
    .req_i          (req_i),
    .req_allow_in_o (req_allow_in_o),
    .refill_i       (refill_i),
    .sc_valid_o     (sc_valid_o),
    .sc_ready_i     (sc_ready_i),
    .sc_o           (sc_o)
  );

  always #10 clk_i = ~clk_i;

  // valid and ready seen here complete on the next rising edge
  always @(negedge clk_i) begin
    if (!rst_i && sc_valid_o && sc_ready_i) begin
      issued_q.push_back(sc_o);
    end
  end

  function automatic logic [LINE_IDX_W-1:0] line_of(input isu_req_t req);
    return req.set_way_offset[6:1];
  endfunction

  // eviction first, then linefill, then write
  function automatic sc_opcode_e expected_opcode(input isu_req_t req);
    sc_opcode_e op;
    if (req.opcode[1]) begin
      op = WRITE_BACK;
    end else if (req.need_linefill) begin
      op = READ_LINEFILL;
    end else if (req.opcode[0]) begin
      op = WRITE;
    end else begin
      op = READ;
    end
    return op;
  endfunction

  task automatic add_row(input int t, input bit infl, input bit lf, input logic [1:0] ch,
                         input logic [1:0] op, input logic [6:0] swo, input logic [7:0] wbuf,
                         input bit refill, input int order);
    req_row_t row;
    row.test_id                = t;
    row.req.cacheline_inflight = infl;
    row.req.need_linefill      = lf;
    row.req.rob_id             = 3'(row_count);
    row.req.ch_id              = ch;
    row.req.opcode             = op;
    row.req.set_way_offset     = swo;
    row.req.wbuffer_id         = wbuf;
    row.req.state0             = 2'(row_count);
    row.req.state1             = 2'(row_count + 1);
    row.refill                 = refill;
    row.order                  = order;
    rows[row_count]            = row;
    row_count++;
  endtask

  // --------------------------------------------------
  // stimulus table
  // --------------------------------------------------
  task automatic load_table();
    // test, inflight, linefill, channel, opcode, set_way_offset, wbuffer, refill, order
    add_row(2, 1'b0, 1'b0, 2'd0, 2'b00, 7'h02, 8'h11, 1'b0, 0);
    add_row(2, 1'b0, 1'b0, 2'd1, 2'b01, 7'h05, 8'h12, 1'b0, 1);
    add_row(2, 1'b0, 1'b0, 2'd2, 2'b10, 7'h06, 8'h13, 1'b0, 2);
    add_row(2, 1'b0, 1'b0, 2'd3, 2'b11, 7'h09, 8'h14, 1'b0, 3);
    add_row(3, 1'b0, 1'b1, 2'd1, 2'b01, 7'h14, 8'h21, 1'b1, 2);
    add_row(3, 1'b0, 1'b0, 2'd2, 2'b00, 7'h17, 8'h22, 1'b0, 0);
    add_row(3, 1'b0, 1'b0, 2'd0, 2'b01, 7'h10, 8'h23, 1'b0, 1);
    add_row(4, 1'b1, 1'b0, 2'd3, 2'b01, 7'h18, 8'h31, 1'b1, 1);
    add_row(4, 1'b0, 1'b0, 2'd1, 2'b00, 7'h1c, 8'h32, 1'b0, 0);
    add_row(5, 1'b0, 1'b0, 2'd0, 2'b00, 7'h20, 8'h41, 1'b0, 0);
    add_row(5, 1'b0, 1'b0, 2'd1, 2'b01, 7'h23, 8'h42, 1'b0, 1);
    add_row(5, 1'b0, 1'b1, 2'd2, 2'b10, 7'h24, 8'h43, 1'b1, 7);
    add_row(5, 1'b0, 1'b0, 2'd3, 2'b00, 7'h26, 8'h44, 1'b0, 2);
    add_row(5, 1'b0, 1'b0, 2'd0, 2'b11, 7'h29, 8'h45, 1'b0, 3);
    add_row(5, 1'b1, 1'b0, 2'd1, 2'b00, 7'h2a, 8'h46, 1'b1, 8);
    add_row(5, 1'b0, 1'b0, 2'd2, 2'b01, 7'h2c, 8'h47, 1'b0, 4);
    add_row(5, 1'b0, 1'b0, 2'd3, 2'b00, 7'h2f, 8'h48, 1'b0, 5);
    ninth_row = row_count;
    add_row(5, 1'b0, 1'b0, 2'd1, 2'b01, 7'h30, 8'h49, 1'b0, 6);
    add_row(6, 1'b0, 1'b1, 2'd2, 2'b00, 7'h3d, 8'h51, 1'b1, 0);
  endtask

  task automatic send_req(input isu_req_t req);
    int waited;
    waited = 0;
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_i       <= req;
    @(negedge clk_i);
    while (!req_allow_in_o && !timed_out) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("timeout: request was never accepted");
        timed_out = 1'b1;
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    req_valid_i <= 1'b0;
  endtask

  task automatic send_refill(input logic [LINE_IDX_W-1:0] idx);
    biu_refill_t beat;
    beat.valid = 1'b1;
    beat.rid   = idx;
    make_line(beat.data);
    line_model[idx] = beat.data;
    line_known[idx] = 1'b1;
    @(posedge clk_i);
    refill_i <= beat;
    @(posedge clk_i);
    refill_i.valid <= 1'b0;
  endtask

  task automatic wait_issues(input int n);
    int waited;
    waited = 0;
    while (issued_q.size() < n && !timed_out) begin
      @(posedge clk_i);
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("timeout: only %0d of %0d issues seen", issued_q.size(), n);
        timed_out = 1'b1;
      end
    end
  endtask

  // nothing else may leave the queue during the window
  task automatic hold_check(input int n);
    repeat (HOLD_CYCLES) @(posedge clk_i);
    assert (issued_q.size() == n)
      else report_failure($sformatf("a blocked entry issued early (%0d issues, %0d expected)",
                                    issued_q.size(), n));
  endtask

  task automatic enqueue_group(input int t, input int limit);
    int sent;
    sent = 0;
    for (int r = 0; r < row_count; r++) begin
      if (rows[r].test_id == t && sent < limit) begin
        send_req(rows[r].req);
        sent++;
      end
    end
  endtask

  task automatic refill_group(input int t);
    for (int r = 0; r < row_count; r++) begin
      if (rows[r].test_id == t && rows[r].refill) begin
        send_refill(line_of(rows[r].req));
      end
    end
  endtask

  task automatic check_group(input int t, input int base);
    sc_issue_t got;
    isu_req_t  req;
    int        pos;
    int        n;
    n = 0;
    for (int r = 0; r < row_count; r++) begin
      if (rows[r].test_id == t) begin
        req = rows[r].req;
        pos = base + rows[r].order;
        n++;
        assert (pos < issued_q.size())
          else report_failure($sformatf("request %0d of test %0d never issued", r, t));
        if (pos < issued_q.size()) begin
          got = issued_q[pos];
          check_value("sc_o.opcode", expected_opcode(req), got.opcode);
          check_value("sc_o.channel_id", req.ch_id, got.channel_id);
          check_value("sc_o.set_way_offset", req.set_way_offset, got.set_way_offset);
          check_value("sc_o.wbuffer_id", req.wbuffer_id, got.wbuffer_id);
          check_value("sc_o.rob_num", req.rob_id, got.rob_num);
          check_value("sc_o.state0", req.state0, got.state0);
          check_value("sc_o.state1", req.state1, got.state1);
          if (line_known[line_of(req)]) begin
            check_value("sc_o.data0", line_model[line_of(req)][HALF_BITS-1:0], got.data0);
            check_value("sc_o.data1", line_model[line_of(req)][LINE_BITS-1:HALF_BITS],
                        got.data1);
          end
        end
      end
    end
    assert (issued_q.size() == base + n)
      else report_failure($sformatf("test %0d saw %0d issues, expected %0d",
                                    t, issued_q.size() - base, n));
  endtask

  task automatic finish_test(input string name);
    test_count++;
    if (test_errors == 0) begin
      $display("test %0d %s: ok", test_count, name);
    end else begin
      $display("test %0d %s: %0d mismatches", test_count, name, test_errors);
    end
    test_errors = 0;
  endtask

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial begin
    int base;
    clk_i       = 1'b0;
    rst_i       = 1'b1;
    req_valid_i = 1'b0;
    req_i       = '0;
    refill_i    = '0;
    sc_ready_i  = 1'b0;
    lfsr_state  = LFSR_SEED;
    line_known  = '0;
    row_count   = 0;
    test_count  = 0;
    check_count = 0;
    error_count = 0;
    test_errors = 0;
    timed_out   = 1'b0;
    load_table();
    repeat (8) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    check_value("sc_valid_o", 1'b0, sc_valid_o);
    check_value("req_allow_in_o", 1'b1, req_allow_in_o);
    finish_test("reset state");

    @(posedge clk_i);
    sc_ready_i <= 1'b1;
    base = issued_q.size();
    enqueue_group(2, MAX_ROWS);
    wait_issues(base + 4);
    check_group(2, base);
    finish_test("hits in order");

    // younger hits pass the waiting linefill
    base = issued_q.size();
    enqueue_group(3, MAX_ROWS);
    wait_issues(base + 2);
    hold_check(base + 2);
    refill_group(3);
    wait_issues(base + 3);
    check_group(3, base);
    finish_test("linefill after refill");

    base = issued_q.size();
    enqueue_group(4, MAX_ROWS);
    wait_issues(base + 1);
    send_refill(6'd13);
    hold_check(base + 1);
    refill_group(4);
    wait_issues(base + 2);
    check_group(4, base);
    finish_test("inflight hit");

    // fill all eight slots under back-pressure
    @(posedge clk_i);
    sc_ready_i <= 1'b0;
    base = issued_q.size();
    enqueue_group(5, 8);
    @(negedge clk_i);
    check_value("req_allow_in_o", 1'b0, req_allow_in_o);
    fork
      send_req(rows[ninth_row].req);
      begin
        hold_check(base);
        @(negedge clk_i);
        check_value("req_allow_in_o", 1'b0, req_allow_in_o);
        @(posedge clk_i);
        sc_ready_i <= 1'b1;
      end
    join
    wait_issues(base + 7);
    hold_check(base + 7);
    refill_group(5);
    wait_issues(base + 9);
    check_group(5, base);
    finish_test("full queue drain");

    // the early beat must not count for the later request
    base = issued_q.size();
    send_refill(6'd30);
    enqueue_group(6, MAX_ROWS);
    hold_check(base);
    refill_group(6);
    wait_issues(base + 1);
    check_group(6, base);
    finish_test("refill before enqueue");

    $display("tests %0d, checks %0d, errors %0d, timeout %0d",
             test_count, check_count, error_count, timed_out);
    if (error_count == 0 && !timed_out) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+verif
logic/cache_pkg.sv
logic/bus_pkg.sv
logic/shift_priority_arb.sv
logic/linefill_buffer.sv
logic/bank_isu_iq.sv
logic/bank_isu_top.sv
verif/bank_isu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the bank issue testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found"
  exit 1
fi

if ! verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module bank_isu_tb -Mdir obj_dir -f sources.f; then
  echo "compile failed"
  exit 1
fi

output="$(./obj_dir/Vbank_isu_tb)"
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TESTBENCH PASSED"; then
  exit 0
fi
exit 1
